//--- bench/abacus_tb.sv
`timescale 1ns/1ps
`include "abacus_defines.svh"

module abacus_tb
	import abacus_pkg::*;
();

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	rv_instr_u   instr;
	logic        instr_issued;
	logic [8:0]  ev;
	logic [15:0] lfsr;
	string       lines[$];
	string       t_name;
	int          t_checks;
	int          t_errs;
	int          tests;
	int          checks;
	int          errors;
	int          cycles;
	int          limit;
	int unsigned tally[9];

	abacus_top uut
	(
		.clk(clk), .rst(rst),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.instr_i(instr), .instr_issued_i(instr_issued),
		.branch_mispredict_i(ev[0]), .ras_mispredict_i(ev[1]),
		.issue_no_instr_i(ev[2]), .issue_no_id_i(ev[3]), .issue_flush_i(ev[4]),
		.issue_unit_busy_i(ev[5]), .issue_operands_not_ready_i(ev[6]),
		.issue_hold_i(ev[7]), .issue_multi_source_i(ev[8])
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit, raised once the vector file length is known
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("Run stopped at cycle %0d before all tests finished", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic string strip_eol(input string s);
		string t;
		t = s;
		while (t.len() > 0 && (t.getc(t.len() - 1) == 8'd10 || t.getc(t.len() - 1) == 8'd13))
			t = t.substr(0, t.len() - 2);
		return t;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		t_checks++;
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			t_errs++;
		end
	endtask

	task automatic protocol_error(input string msg);
		$display("Bus protocol problem: %s", msg);
		t_errs++;
	endtask

	task automatic finish_test();
		if (t_name != "")
		begin
			$display("%-12s %0d checks, %0d errors", t_name, t_checks, t_errs);
			tests++;
			checks += t_checks;
			errors += t_errs;
		end
		t_name = "";
	endtask

	task automatic start_test(input string name);
		finish_test();
		t_name = name;
		t_checks = 0;
		t_errs = 0;
	endtask

	// One Wishbone cycle, with ack expected one cycle after stb and for one cycle only
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int n;
		n = 0;
		@(posedge clk);
		instr_issued <= 1'b0;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= we;
		wb_adr <= adr;
		wb_dat <= wdat;
		do
		begin
			@(posedge clk);
			n++;
		end while (!wb_ack_o && n < 10);
		rdat = wb_dat_o;
		if (!wb_ack_o)
			protocol_error($sformatf("no acknowledge for address %h", adr));
		else if (n != 2)
			protocol_error($sformatf("acknowledge for %h came %0d cycles after stb", adr, n - 1));
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		@(posedge clk);
		if (wb_ack_o)
			protocol_error($sformatf("acknowledge for %h lasted more than one cycle", adr));
	endtask

	task automatic write_reg(input logic [31:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_check(input logic [31:0] adr, input logic [31:0] exp);
		logic [31:0] got;
		bus_cycle(1'b0, adr, 32'h0, got);
		compare($sformatf("wb_dat_o[%h]", adr), got, exp);
	endtask

	task automatic issue(input logic [31:0] word);
		@(posedge clk);
		instr <= word;
		instr_issued <= 1'b1;
	endtask

	task automatic stall_burst(input logic count_it);
		logic [8:0] pat;
		for (int c = 0; c < 200; c++)
		begin
			@(posedge clk);
			for (int b = 0; b < 9; b++)
				pat[b] = next_rand_bit();
			ev <= pat;
			for (int b = 0; b < 9; b++)
				if (count_it && pat[b])
					tally[b]++;
		end
		@(posedge clk);
		ev <= '0;
	endtask

	task automatic check_stall_counters();
		for (int i = 0; i < 9; i++)
			read_check(`ABACUS_BASE_ADDR + `ABACUS_STALL_BASE_OFS + 4 * i, tally[i]);
	endtask

	task automatic run_vectors();
		logic [31:0] a;
		logic [31:0] d;
		byte         op;
		foreach (lines[k])
		begin
			op = lines[k].getc(0);
			case (op)
				"T": start_test(lines[k].substr(2, lines[k].len() - 1));
				"W":
				begin
					void'($sscanf(lines[k].substr(1, lines[k].len() - 1), "%h %h", a, d));
					write_reg(a, d);
				end
				"I":
				begin
					void'($sscanf(lines[k].substr(1, lines[k].len() - 1), "%h", a));
					issue(a);
				end
				"R":
				begin
					void'($sscanf(lines[k].substr(1, lines[k].len() - 1), "%h %h", a, d));
					read_check(a, d);
				end
				default: protocol_error($sformatf("unknown vector line '%s'", lines[k]));
			endcase
		end
	endtask

	initial
	begin
		int    fd;
		string line;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		instr = '0;
		instr_issued = 1'b0;
		ev = '0;
		lfsr = 16'd75;
		cycles = 0;
		limit = 4000;
		t_name = "";
		fd = $fopen("bench/abacus_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open bench/abacus_vectors.txt");
			$display("Test failed");
			$finish;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				line = strip_eol(line);
				if (line.len() > 0 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
			limit = 30 * lines.size() + 4000;
			repeat (16) @(posedge clk);
			rst <= 1'b0;
			@(posedge clk);

			start_test("reset");
			compare("wb_ack_o", 32'(wb_ack_o), 32'h0);
			read_check(`ABACUS_BASE_ADDR + `ABACUS_IPROF_EN_OFS, 32'h0);
			read_check(`ABACUS_BASE_ADDR + `ABACUS_STALL_EN_OFS, 32'h0);
			for (int i = 0; i < `ABACUS_IPROF_NUM; i++)
				read_check(`ABACUS_BASE_ADDR + `ABACUS_IPROF_BASE_OFS + 4 * i, 32'h0);
			check_stall_counters();

			run_vectors();

			// Second burst runs with the stall profiler off and must not move the counts
			start_test("stall");
			write_reg(`ABACUS_BASE_ADDR + `ABACUS_STALL_EN_OFS, 32'h1);
			stall_burst(1'b1);
			check_stall_counters();
			write_reg(`ABACUS_BASE_ADDR + `ABACUS_STALL_EN_OFS, 32'h0);
			stall_burst(1'b0);
			check_stall_counters();
			finish_test();

			$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0)
				$display("Test passed");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

//--- bench/abacus_vectors.txt
# T name starts a test | W addr data | I instruction word | R addr expected read data
# All numbers are hex
T registers
W f0030004 a5a5a5a5
R f0030004 a5a5a5a5
W f003000c 12345678
R f003000c 12345678
W f0030100 ffffffff
R f0030100 00000000
R f0030008 00000000
T classify
I 00012083
I 00112023
I 002081b3
I 00500093
I 402081b3
I 0020f1b3
I 4030d093
I 0020a1b3
I 00208063
I 000000ef
I 00000073
I 0020a1af
I 022081b3
I 30009073
R f0030100 00000001
R f0030104 00000001
R f0030108 00000002
R f003010c 00000001
R f0030110 00000001
R f0030114 00000001
R f0030118 00000001
R f003011c 00000001
R f0030120 00000001
R f0030124 00000001
R f0030128 00000001
T disable
W f0030004 00000000
I 002081b3
I 00012083
R f0030108 00000002
R f0030100 00000001

//--- flist.f
+incdir+include
rtl/abacus_pkg.sv
rtl/abacus_wb_regs.sv
rtl/instruction_profiler.sv
rtl/stall_profiler.sv
rtl/abacus_top.sv
bench/abacus_tb.sv

//--- include/abacus_defines.svh
`ifndef ABACUS_DEFINES_SVH
`define ABACUS_DEFINES_SVH

// Bus and counter width
`define ABACUS_DATA_W 32

// Base of the register block on the Wishbone bus
`define ABACUS_BASE_ADDR 32'hF003_0000

// Enable register offsets from the base
`define ABACUS_IPROF_EN_OFS 32'h0000_0004
`define ABACUS_STALL_EN_OFS 32'h0000_000C

// Counter window offsets, one word per counter
`define ABACUS_IPROF_BASE_OFS 32'h0000_0100
`define ABACUS_STALL_BASE_OFS 32'h0000_0300

// Counters per profiler
`define ABACUS_IPROF_NUM 11
`define ABACUS_STALL_NUM 9

// Word index within a counter window
`define ABACUS_IDX_W 4

`endif

//--- rtl/abacus_pkg.sv
`include "abacus_defines.svh"

package abacus_pkg;

	// One RV32 instruction word seen as R-type or I-type
	typedef union packed
	{
		struct packed
		{
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed
		{
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
	} rv_instr_u;

	typedef enum logic [6:0]
	{
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_SYSTEM = 7'b1110011,
		OPC_AMO    = 7'b0101111
	} rv_opcode_e;

	// Class order matches the counter address order
	typedef enum logic [`ABACUS_IDX_W-1:0]
	{
		CLS_LOAD_WORD, CLS_STORE_WORD, CLS_ADD, CLS_SUB, CLS_LOGICAL, CLS_SHIFT,
		CLS_COMPARE, CLS_BRANCH, CLS_JUMP, CLS_SYS_PRIV, CLS_ATOMIC
	} iprof_class_e;

	typedef logic [`ABACUS_DATA_W-1:0] counter_t;

endpackage

//--- rtl/abacus_top.sv
`timescale 1ns/1ps
`include "abacus_defines.svh"

module abacus_top
	import abacus_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,

	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  logic [`ABACUS_DATA_W-1:0] wb_adr_i,
	input  logic [`ABACUS_DATA_W-1:0] wb_dat_i,
	output logic [`ABACUS_DATA_W-1:0] wb_dat_o,
	output logic                      wb_ack_o,

	input  rv_instr_u                 instr_i,
	input  logic                      instr_issued_i,

	input  logic                      branch_mispredict_i,
	input  logic                      ras_mispredict_i,
	input  logic                      issue_no_instr_i,
	input  logic                      issue_no_id_i,
	input  logic                      issue_flush_i,
	input  logic                      issue_unit_busy_i,
	input  logic                      issue_operands_not_ready_i,
	input  logic                      issue_hold_i,
	input  logic                      issue_multi_source_i
);

	logic                    iprof_en;
	logic                    stall_en;
	logic [`ABACUS_IDX_W-1:0] rd_idx;
	counter_t                iprof_rd_data;
	counter_t                stall_rd_data;

	abacus_wb_regs u_wb_regs
	(
		.clk(clk), .rst(rst),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.iprof_rd_data_i(iprof_rd_data), .stall_rd_data_i(stall_rd_data),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.iprof_en_o(iprof_en), .stall_en_o(stall_en), .rd_idx_o(rd_idx)
	);

	instruction_profiler u_iprof
	(
		.clk(clk), .rst(rst), .en_i(iprof_en),
		.instr_i(instr_i), .instr_issued_i(instr_issued_i),
		.rd_idx_i(rd_idx), .rd_data_o(iprof_rd_data)
	);

	stall_profiler u_stall
	(
		.clk(clk), .rst(rst), .en_i(stall_en),
		.branch_mispredict_i(branch_mispredict_i), .ras_mispredict_i(ras_mispredict_i),
		.issue_no_instr_i(issue_no_instr_i), .issue_no_id_i(issue_no_id_i),
		.issue_flush_i(issue_flush_i), .issue_unit_busy_i(issue_unit_busy_i),
		.issue_operands_not_ready_i(issue_operands_not_ready_i),
		.issue_hold_i(issue_hold_i), .issue_multi_source_i(issue_multi_source_i),
		.rd_idx_i(rd_idx), .rd_data_o(stall_rd_data)
	);

endmodule

//--- rtl/abacus_wb_regs.sv
`timescale 1ns/1ps
`include "abacus_defines.svh"

module abacus_wb_regs
	import abacus_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  logic [`ABACUS_DATA_W-1:0] wb_adr_i,
	input  logic [`ABACUS_DATA_W-1:0] wb_dat_i,
	input  counter_t                  iprof_rd_data_i,
	input  counter_t                  stall_rd_data_i,
	output logic [`ABACUS_DATA_W-1:0] wb_dat_o,
	output logic                      wb_ack_o,
	output logic                      iprof_en_o,
	output logic                      stall_en_o,
	output logic [`ABACUS_IDX_W-1:0]  rd_idx_o
);

	logic [`ABACUS_DATA_W-1:0] iprof_en_q;
	logic [`ABACUS_DATA_W-1:0] stall_en_q;
	logic [`ABACUS_DATA_W-1:0] ofs;
	logic [`ABACUS_DATA_W-1:0] iprof_ofs;
	logic [`ABACUS_DATA_W-1:0] stall_ofs;
	logic                      iprof_hit;
	logic                      stall_hit;
	logic                      req;

	assign req = wb_cyc_i & wb_stb_i;

	// Offsets wrap below their base, so one compare covers both ends of a window
	assign ofs       = wb_adr_i - `ABACUS_BASE_ADDR;
	assign iprof_ofs = ofs - `ABACUS_IPROF_BASE_OFS;
	assign stall_ofs = ofs - `ABACUS_STALL_BASE_OFS;
	assign iprof_hit = (iprof_ofs[1:0] == 2'b00) && (iprof_ofs[31:2] < `ABACUS_IPROF_NUM);
	assign stall_hit = (stall_ofs[1:0] == 2'b00) && (stall_ofs[31:2] < `ABACUS_STALL_NUM);

	// Word index shared by both profilers
	assign rd_idx_o = iprof_hit ? iprof_ofs[`ABACUS_IDX_W+1:2] : stall_ofs[`ABACUS_IDX_W+1:2];

	assign iprof_en_o = iprof_en_q[0];
	assign stall_en_o = stall_en_q[0];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wb_ack_o   <= 1'b0;
			iprof_en_q <= '0;
			stall_en_q <= '0;
		end
		else
		begin
			// A held request is answered every other cycle
			wb_ack_o <= req & ~wb_ack_o;
			if (req && wb_we_i && !wb_ack_o)
			begin
				if (ofs == `ABACUS_IPROF_EN_OFS)
					iprof_en_q <= wb_dat_i;
				else if (ofs == `ABACUS_STALL_EN_OFS)
					stall_en_q <= wb_dat_i;
			end
		end
	end

	// Read data follows the address and unmapped words read zero
	always_comb
	begin
		wb_dat_o = '0;
		if (req && !wb_we_i)
		begin
			if (ofs == `ABACUS_IPROF_EN_OFS)
				wb_dat_o = iprof_en_q;
			else if (ofs == `ABACUS_STALL_EN_OFS)
				wb_dat_o = stall_en_q;
			else if (iprof_hit)
				wb_dat_o = iprof_rd_data_i;
			else if (stall_hit)
				wb_dat_o = stall_rd_data_i;
		end
	end

	// The master keeps a request up until it is acknowledged
	req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
		req && !wb_ack_o |=> req);

endmodule

//--- rtl/instruction_profiler.sv
`timescale 1ns/1ps
`include "abacus_defines.svh"

module instruction_profiler
	import abacus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     en_i,
	input  rv_instr_u                instr_i,
	input  logic                     instr_issued_i,
	input  logic [`ABACUS_IDX_W-1:0] rd_idx_i,
	output counter_t                 rd_data_o
);

	// SYSTEM immediates that count as privileged
	localparam logic [11:0] IMM_ECALL  = 12'h000;
	localparam logic [11:0] IMM_EBREAK = 12'h001;
	localparam logic [11:0] IMM_MRET   = 12'h302;
	localparam logic [11:0] IMM_WFI    = 12'h105;

	logic [6:0]                   opcode;
	logic [2:0]                   funct3;
	logic [6:0]                   funct7;
	logic [11:0]                  imm12;
	logic                         is_op;
	logic                         is_op_imm;
	logic                         alu;
	logic                         priv_imm;
	logic [`ABACUS_IPROF_NUM-1:0] class_hit;
	counter_t                     cnt [`ABACUS_IPROF_NUM];

	assign opcode = instr_i.r.opcode;
	assign funct3 = instr_i.r.funct3;
	assign funct7 = instr_i.r.funct7;
	assign imm12  = instr_i.i.imm12;

	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);

	// Multiply and divide share OP, keep them out of the ALU classes
	assign alu = is_op_imm || (is_op && funct7 != 7'h01);

	assign priv_imm = (imm12 == IMM_ECALL) || (imm12 == IMM_EBREAK) ||
		(imm12 == IMM_MRET) || (imm12 == IMM_WFI);

	always_comb
	begin
		class_hit = '0;
		class_hit[CLS_LOAD_WORD]  = (opcode == OPC_LOAD) && (funct3 == 3'd2);
		class_hit[CLS_STORE_WORD] = (opcode == OPC_STORE) && (funct3 == 3'd2);
		class_hit[CLS_ADD]        = (funct3 == 3'd0) &&
			((is_op && funct7 == 7'h00) || is_op_imm);
		class_hit[CLS_SUB]        = is_op && (funct3 == 3'd0) && (funct7 == 7'h20);
		class_hit[CLS_LOGICAL]    = alu && (funct3 == 3'd4 || funct3 == 3'd6 || funct3 == 3'd7);
		class_hit[CLS_SHIFT]      = alu && (funct3 == 3'd1 || funct3 == 3'd5);
		class_hit[CLS_COMPARE]    = alu && (funct3 == 3'd2 || funct3 == 3'd3);
		class_hit[CLS_BRANCH]     = (opcode == OPC_BRANCH);
		class_hit[CLS_JUMP]       = (opcode == OPC_JAL) || (opcode == OPC_JALR);
		class_hit[CLS_SYS_PRIV]   = (opcode == OPC_SYSTEM) && (funct3 == 3'd0) && priv_imm;
		class_hit[CLS_ATOMIC]     = (opcode == OPC_AMO);
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `ABACUS_IPROF_NUM; i++)
				cnt[i] <= '0;
		end
		else if (en_i && instr_issued_i)
		begin
			// Counters wrap freely
			for (int i = 0; i < `ABACUS_IPROF_NUM; i++)
				if (class_hit[i])
					cnt[i] <= cnt[i] + 1'b1;
		end
	end

	assign rd_data_o = (rd_idx_i < `ABACUS_IPROF_NUM) ? cnt[rd_idx_i] : '0;

	class_exclusive: assert property (@(posedge clk) disable iff (rst)
		instr_issued_i |-> $onehot0(class_hit));

endmodule

//--- rtl/stall_profiler.sv
`timescale 1ns/1ps
`include "abacus_defines.svh"

module stall_profiler
	import abacus_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     en_i,
	input  logic                     branch_mispredict_i,
	input  logic                     ras_mispredict_i,
	input  logic                     issue_no_instr_i,
	input  logic                     issue_no_id_i,
	input  logic                     issue_flush_i,
	input  logic                     issue_unit_busy_i,
	input  logic                     issue_operands_not_ready_i,
	input  logic                     issue_hold_i,
	input  logic                     issue_multi_source_i,
	input  logic [`ABACUS_IDX_W-1:0] rd_idx_i,
	output counter_t                 rd_data_o
);

	logic [`ABACUS_STALL_NUM-1:0] ev;
	counter_t                     cnt [`ABACUS_STALL_NUM];

	// Bit order is the counter address order, branch mispredict at index 0
	assign ev = {issue_multi_source_i, issue_hold_i, issue_operands_not_ready_i,
		issue_unit_busy_i, issue_flush_i, issue_no_id_i, issue_no_instr_i,
		ras_mispredict_i, branch_mispredict_i};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `ABACUS_STALL_NUM; i++)
				cnt[i] <= '0;
		end
		else if (en_i)
		begin
			for (int i = 0; i < `ABACUS_STALL_NUM; i++)
				if (ev[i])
					cnt[i] <= cnt[i] + 1'b1;
		end
	end

	assign rd_data_o = (rd_idx_i < `ABACUS_STALL_NUM) ? cnt[rd_idx_i] : '0;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the abacus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module abacus_tb -o abacus_sim
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

out=$(./obj_dir/abacus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
